// File: source/game_consts.svh
`ifndef GAME_CONSTS_SVH
`define GAME_CONSTS_SVH

`define GAME_COORD_W          9              // screen coordinates fit in 9 bits
`define GAME_PERIOD_W         28             // tick period registers

`define GAME_START_X          9'd0           // player spawns at the left edge
`define GAME_START_Y          9'd181         // standing on the ground line
`define GAME_STEP             9'd4           // pixels per move, both axes

`define GAME_X_TURN_LEFT      9'd300         // sprite is 20 wide, so turn 20 before the edge
`define GAME_X_TURN_RIGHT     9'd3
`define GAME_JUMP_LIMIT       9'd79          // max rise before gravity takes over
`define GAME_Y_TOP            9'd4           // never rise past the top row
`define GAME_GROUND_Y         9'd181

`define GAME_MID_Y_LO         9'd102         // middle level, left and right ledges
`define GAME_MID_Y_HI         9'd106
`define GAME_MID_L_X_LO       9'd0
`define GAME_MID_L_X_HI       9'd109
`define GAME_MID_R_X_LO       9'd191
`define GAME_MID_R_X_HI       9'd301
`define GAME_TOP_Y_LO         9'd52          // upper level, left and right ledges
`define GAME_TOP_Y_HI         9'd56
`define GAME_TOP_L_X_LO       9'd30
`define GAME_TOP_L_X_HI       9'd109
`define GAME_TOP_R_X_LO       9'd191
`define GAME_TOP_R_X_HI       9'd268
`define GAME_PEAK_Y_LO        9'd10          // top middle ledge that carries the goal
`define GAME_PEAK_Y_HI        9'd13
`define GAME_PEAK_X_LO        9'd117
`define GAME_PEAK_X_HI        9'd183

`define GAME_WIN_Y_LO         9'd10          // reaching this window ends the game
`define GAME_WIN_Y_HI         9'd13
`define GAME_WIN_X_LO         9'd133
`define GAME_WIN_X_HI         9'd187

`define GAME_FRAME_PERIOD_DEF 28'd3255731    // roughly 15 moves per second at 50 MHz
`define GAME_TIMER_PERIOD_DEF 28'd4999999    // tenth of a second at 50 MHz

`endif

// File: source/gamePkg.sv
package gamePkg;

	// game FSM states
	typedef enum logic [1:0] {
		init,                       // one cycle after reset
		play,                       // waiting for the frame tick
		update,                     // move the player once
		endgame                     // goal reached, frozen until reset
	} gameState;

	// horizontal walking direction
	typedef enum logic {
		left,
		right
	} xDir;

	// vertical motion mode
	typedef enum logic [1:0] {
		rising,                     // jump in progress
		falling,                    // gravity
		resting                     // standing on ground or ledge
	} yMode;

	// anchor is the bottom left corner of the sprite
	typedef struct packed {
		logic [8:0] x;
		logic [8:0] y;
	} playerPos;

endpackage

// File: source/timerPkg.sv
package timerPkg;

	typedef enum logic {
		cfgFramePeriod,             // frame tick period register
		cfgTimerPeriod              // elapsed timer tick period register
	} cfgAddr;

	typedef struct packed {
		logic        strobe;        // one cycle write request
		cfgAddr      addr;
		logic [27:0] data;
	} cfgWrite;

	typedef logic [3:0] bcdDigit;

	// active low segments, bit 6 is segment g
	typedef struct packed {
		logic [6:0] digit5;
		logic [6:0] digit4;
		logic [6:0] digit3;
		logic [6:0] digit2;
		logic [6:0] digit1;
		logic [6:0] digit0;
	} hexDisplay;

endpackage

// File: source/gameConfig.sv
`include "game_consts.svh"

module gameConfig (
	input  logic                      clk,
	input  logic                      reset,
	input  timerPkg::cfgWrite         cfg,
	output logic [`GAME_PERIOD_W-1:0] framePeriod,
	output logic [`GAME_PERIOD_W-1:0] timerPeriod,
	output logic                      frameRestart,
	output logic                      timerRestart
);
	import timerPkg::*;

	// restart goes out with the write so the counter starts clean next cycle
	assign frameRestart = cfg.strobe && (cfg.addr == cfgFramePeriod);
	assign timerRestart = cfg.strobe && (cfg.addr == cfgTimerPeriod);

	always_ff @(posedge clk) begin
		if (reset) begin
			framePeriod <= `GAME_FRAME_PERIOD_DEF;   // hardware rates out of reset
			timerPeriod <= `GAME_TIMER_PERIOD_DEF;
		end else begin
			if (frameRestart) begin
				framePeriod <= cfg.data;             // visible the cycle after the strobe
			end
			if (timerRestart) begin
				timerPeriod <= cfg.data;
			end
		end
	end

endmodule

// File: source/tickGenerator.sv
`include "game_consts.svh"

module tickGenerator (
	input  logic                      clk,
	input  logic                      reset,
	input  logic [`GAME_PERIOD_W-1:0] framePeriod,
	input  logic [`GAME_PERIOD_W-1:0] timerPeriod,
	input  logic                      frameRestart,
	input  logic                      timerRestart,
	output logic                      frameTick,
	output logic                      timerTick
);

	logic [`GAME_PERIOD_W-1:0] period [2];   // index 0 frame, 1 timer
	logic [`GAME_PERIOD_W-1:0] count [2];
	logic [1:0]                restart;
	logic [1:0]                tick;

	assign period[0] = framePeriod;
	assign period[1] = timerPeriod;
	assign restart   = {timerRestart, frameRestart};

	always_comb begin
		for (int i = 0; i < 2; i++) begin
			tick[i] = (count[i] == period[i]);   // one cycle at the top of the count
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < 2; i++) begin
			if (reset || restart[i] || tick[i]) begin
				count[i] <= '0;                      // wrap so ticks come every period+1 cycles
			end else begin
				count[i] <= count[i] + `GAME_PERIOD_W'(1);
			end
		end
	end

	assign frameTick = tick[0];
	assign timerTick = tick[1];

endmodule

// File: source/gameControl.sv
module gameControl (
	input  logic clk,
	input  logic reset,
	input  logic frameTick,
	input  logic onWin,
	output logic step,
	output logic win
);
	import gamePkg::*;

	gameState state;
	gameState nextState;

	always_comb begin
		nextState = state;
		case (state)
			init: begin
				nextState = play;                    // nothing to clear without a screen
			end
			play: begin
				if (frameTick) begin
					nextState = update;
				end
			end
			update: begin
				nextState = onWin ? endgame : play;  // goal check before the move
			end
			endgame: begin
				nextState = endgame;                 // only reset leaves
			end
			default: begin
				nextState = init;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= init;
		end else begin
			state <= nextState;
		end
	end

	assign step = (state == update) && !onWin;     // one move per frame tick
	assign win  = (state == endgame);

endmodule

// File: source/platformMap.sv
`include "game_consts.svh"

module platformMap (
	input  gamePkg::playerPos pos,
	output logic              onSurface,
	output logic              onWin
);

	function automatic logic inRange(input logic [`GAME_COORD_W-1:0] v, lo, hi);
		return (v >= lo) && (v <= hi);               // inclusive window
	endfunction

	logic onGround;
	logic onMid;
	logic onTop;
	logic onPeak;

	assign onGround = (pos.y >= `GAME_GROUND_Y);
	assign onMid    = inRange(pos.y, `GAME_MID_Y_LO, `GAME_MID_Y_HI)
		&& (inRange(pos.x, `GAME_MID_L_X_LO, `GAME_MID_L_X_HI)
		|| inRange(pos.x, `GAME_MID_R_X_LO, `GAME_MID_R_X_HI));
	assign onTop    = inRange(pos.y, `GAME_TOP_Y_LO, `GAME_TOP_Y_HI)
		&& (inRange(pos.x, `GAME_TOP_L_X_LO, `GAME_TOP_L_X_HI)
		|| inRange(pos.x, `GAME_TOP_R_X_LO, `GAME_TOP_R_X_HI));
	assign onPeak   = inRange(pos.y, `GAME_PEAK_Y_LO, `GAME_PEAK_Y_HI)
		&& inRange(pos.x, `GAME_PEAK_X_LO, `GAME_PEAK_X_HI);

	// windows are a few rows deep since y moves in steps of 4
	assign onSurface = onGround || onMid || onTop || onPeak;

	// goal window reaches a little past the right end of the peak ledge
	assign onWin = inRange(pos.y, `GAME_WIN_Y_LO, `GAME_WIN_Y_HI)
		&& inRange(pos.x, `GAME_WIN_X_LO, `GAME_WIN_X_HI);

endmodule

// File: source/playerMotion.sv
`include "game_consts.svh"

module playerMotion (
	input  logic              clk,
	input  logic              reset,
	input  logic              step,
	input  logic              jump,
	input  logic              onSurface,
	output gamePkg::playerPos pos
);
	import gamePkg::*;

	xDir                      dir;
	xDir                      dirNext;
	yMode                     mode;
	yMode                     modeNow;          // mode with this cycle's jump press applied
	yMode                     modeNext;
	logic [`GAME_COORD_W-1:0] jumpHeight;       // pixels risen since takeoff

	always_comb begin
		// a press only counts while standing on something
		modeNow = (jump && onSurface) ? rising : mode;

		dirNext = dir;
		if (pos.x <= `GAME_X_TURN_RIGHT) begin
			dirNext = right;                          // bounce off the left edge
		end else if (pos.x >= `GAME_X_TURN_LEFT) begin
			dirNext = left;
		end

		modeNext = modeNow;
		if (modeNow == rising
			&& (jumpHeight >= `GAME_JUMP_LIMIT || pos.y < `GAME_Y_TOP)) begin
			modeNext = falling;                       // apex reached or top of screen
		end
		if (modeNext != rising) begin
			modeNext = onSurface ? resting : falling; // walked off a ledge falls
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pos.x      <= `GAME_START_X;
			pos.y      <= `GAME_START_Y;
			dir        <= left;                       // turns right on the first step
			mode       <= resting;
			jumpHeight <= '0;
		end else if (step) begin
			dir  <= dirNext;
			mode <= modeNext;
			if (dirNext == right) begin
				pos.x <= pos.x + `GAME_STEP;
			end else begin
				pos.x <= pos.x - `GAME_STEP;
			end
			case (modeNext)
				rising: begin
					pos.y      <= pos.y - `GAME_STEP;     // screen y grows downward
					jumpHeight <= jumpHeight + `GAME_STEP;
				end
				falling: begin
					pos.y      <= pos.y + `GAME_STEP;
					jumpHeight <= '0;                     // fall height is not tracked
				end
				default: begin
					jumpHeight <= '0;                     // landed so y holds
				end
			endcase
		end else begin
			mode <= modeNow;                          // latch a press between frames
		end
	end

endmodule

// File: source/elapsedTimer.sv
module elapsedTimer (
	input  logic                clk,
	input  logic                reset,
	input  logic                timerTick,
	input  logic                win,
	output timerPkg::hexDisplay display
);
	import timerPkg::*;

	bcdDigit    digits [6];                     // digit 0 is the least significant
	logic [5:0] carry;                          // advance enable per digit

	function automatic logic [6:0] segments(input bcdDigit d);
		case (d)
			4'd0: return 7'b100_0000;
			4'd1: return 7'b111_1001;
			4'd2: return 7'b010_0100;
			4'd3: return 7'b011_0000;
			4'd4: return 7'b001_1001;
			4'd5: return 7'b001_0010;
			4'd6: return 7'b000_0010;
			4'd7: return 7'b111_1000;
			4'd8: return 7'b000_0000;
			4'd9: return 7'b001_1000;
			default: return 7'b111_1111;            // blank for codes above 9
		endcase
	endfunction

	always_comb begin
		logic ripple;
		ripple = timerTick && !win;               // clock stops once the goal is reached
		for (int i = 0; i < 6; i++) begin
			carry[i] = ripple;
			ripple   = ripple && (digits[i] == 4'd9);  // next digit moves on a 9 to 0 wrap
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < 6; i++) begin
			if (reset) begin
				digits[i] <= '0;
			end else if (carry[i]) begin
				digits[i] <= (digits[i] == 4'd9) ? 4'd0 : digits[i] + 4'd1;
			end
		end
	end

	assign display.digit0 = segments(digits[0]);
	assign display.digit1 = segments(digits[1]);
	assign display.digit2 = segments(digits[2]);
	assign display.digit3 = segments(digits[3]);
	assign display.digit4 = segments(digits[4]);
	assign display.digit5 = segments(digits[5]);

endmodule

// File: source/gameTop.sv
`include "game_consts.svh"

module gameTop (
	input  logic                clk,
	input  logic                reset,
	input  logic                jump,           // held button level
	input  timerPkg::cfgWrite   cfg,
	output gamePkg::playerPos   pos,
	output logic                win,
	output timerPkg::hexDisplay display
);

	logic [`GAME_PERIOD_W-1:0] framePeriod;
	logic [`GAME_PERIOD_W-1:0] timerPeriod;
	logic                      frameRestart;
	logic                      timerRestart;
	logic                      frameTick;
	logic                      timerTick;
	logic                      step;
	logic                      onSurface;
	logic                      onWin;

	gameConfig gameConfig_i (.clk, .reset, .cfg, .framePeriod, .timerPeriod,
		.frameRestart, .timerRestart);

	tickGenerator tickGenerator_i (.clk, .reset, .framePeriod, .timerPeriod,
		.frameRestart, .timerRestart, .frameTick, .timerTick);

	gameControl gameControl_i (.clk, .reset, .frameTick, .onWin, .step, .win);

	platformMap platformMap_i (.pos, .onSurface, .onWin);   // same cycle as pos

	playerMotion playerMotion_i (.clk, .reset, .step, .jump, .onSurface, .pos);

	elapsedTimer elapsedTimer_i (
		.clk,
		.reset,
		.timerTick,
		.win,                                       // halts the count
		.display
	);

endmodule

// File: tb/gameTop_sva.sv
module gameTopSva (
	input logic              clk,
	input logic              reset,
	input logic              step,
	input logic              win,
	input gamePkg::playerPos pos
);

	// update always returns to play, so moves never come back to back
	singleStep: assert property (@(posedge clk) disable iff (reset) step |=> !step)
		else $error("step high on two consecutive cycles");

	// game over is sticky until reset
	winHeld: assert property (@(posedge clk) disable iff (reset) win |=> win)
		else $error("win dropped without reset");

	posFrozen: assert property (@(posedge clk) disable iff (reset) win |=> $stable(pos))
		else $error("player moved after the game ended");

	xInRange: assert property (@(posedge clk) disable iff (reset) pos.x <= 9'd316)
		else $error("player x left the screen");

endmodule

bind gameTop gameTopSva gameTopSva_i (.clk, .reset, .step, .win, .pos);

// File: tb/gameTopTb.sv
`include "game_consts.svh"

module gameTopTb;
	import gamePkg::*;
	import timerPkg::*;

	typedef struct packed {
		logic [27:0] framePer;
		logic [27:0] timerPer;
		int unsigned frames;                     // steps to run with these periods
		int unsigned jumpPct;                    // chance of a press per frame
	} testRow;

	localparam int rowCount = 4;
	testRow rows [rowCount] = '{
		'{28'd5, 28'd3, 90, 0},                  // plain walk past both turns
		'{28'd2, 28'd9, 60, 30},
		'{28'd9, 28'd0, 30, 60},                 // timer ticks every cycle
		'{28'd3, 28'd1, 80, 15}
	};
	// standard active low segment patterns for 0 to 9
	logic [6:0] segTable [10] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h18};

	logic clk = 1'b0;
	logic reset;
	logic jump;
	cfgWrite cfg;
	playerPos pos;
	logic win;
	hexDisplay display;
	int seed;

	// reference model state
	logic [27:0] mFramePer;
	logic [27:0] mTimerPer;
	logic [27:0] mFrameCnt;
	logic [27:0] mTimerCnt;
	gameState mState;
	playerPos mPos;
	xDir mDir;
	yMode mMode;
	logic [8:0] mHeight;                         // rise since takeoff
	bcdDigit mDig [6];
	int unsigned stepCount;

	gameTop gameTop_i (.clk, .reset, .jump, .cfg, .pos, .win, .display);

	always #4 clk = ~clk;

	function automatic logic onSurf(input playerPos p);
		logic mid;
		logic top;
		logic peak;
		mid = p.y >= `GAME_MID_Y_LO && p.y <= `GAME_MID_Y_HI && (p.x <= `GAME_MID_L_X_HI
			|| (p.x >= `GAME_MID_R_X_LO && p.x <= `GAME_MID_R_X_HI));
		top = p.y >= `GAME_TOP_Y_LO && p.y <= `GAME_TOP_Y_HI
			&& ((p.x >= `GAME_TOP_L_X_LO && p.x <= `GAME_TOP_L_X_HI)
			|| (p.x >= `GAME_TOP_R_X_LO && p.x <= `GAME_TOP_R_X_HI));
		peak = p.y >= `GAME_PEAK_Y_LO && p.y <= `GAME_PEAK_Y_HI
			&& p.x >= `GAME_PEAK_X_LO && p.x <= `GAME_PEAK_X_HI;
		return p.y >= `GAME_GROUND_Y || mid || top || peak;
	endfunction

	function automatic logic onGoal(input playerPos p);
		return p.y >= `GAME_WIN_Y_LO && p.y <= `GAME_WIN_Y_HI
			&& p.x >= `GAME_WIN_X_LO && p.x <= `GAME_WIN_X_HI;
	endfunction

	// segment patterns of the model digits
	function automatic hexDisplay expectedDisplay();
		return {segTable[mDig[5]], segTable[mDig[4]], segTable[mDig[3]],
			segTable[mDig[2]], segTable[mDig[1]], segTable[mDig[0]]};
	endfunction

	task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
		assert (got === exp) else begin
			$display("Fail time=%0t signal=%s dut=%0h expected=%0h", $time, name, got, exp);
			$display("Finished with errors");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task automatic timeoutFail(input string what);
		$display("Timed out while waiting for %s", what);
		$display("Finished with errors");
		$fatal(1, "wait limit exceeded");
	endtask

	task automatic compareAll();
		checkValue("pos", 64'(pos), 64'(mPos));
		checkValue("win", 64'(win), 64'(mState == endgame));
		checkValue("display", 64'(display), 64'(expectedDisplay()));
	endtask

	// one clock of the game rules, inputs as seen at the next rising edge
	task automatic advanceModel(input logic jumpIn, input cfgWrite c);
		logic fTick;
		logic tTick;
		logic surf;
		logic goal;
		logic carry;
		yMode m;
		fTick = (mFrameCnt == mFramePer);
		tTick = (mTimerCnt == mTimerPer);
		surf = onSurf(mPos);
		goal = onGoal(mPos);
		carry = tTick && (mState != endgame);        // halted once won
		for (int i = 0; i < 6; i++) begin
			if (carry) begin
				carry = (mDig[i] == 4'd9);
				mDig[i] = carry ? 4'd0 : mDig[i] + 4'd1;
			end
		end
		m = (jumpIn && surf) ? rising : mMode;       // press only counts on a surface
		if (mState == update && !goal) begin
			if (mPos.x <= `GAME_X_TURN_RIGHT) mDir = right;
			else if (mPos.x >= `GAME_X_TURN_LEFT) mDir = left;
			if (m == rising && (mHeight >= `GAME_JUMP_LIMIT || mPos.y < `GAME_Y_TOP)) m = falling;
			if (m != rising) m = surf ? resting : falling;
			mPos.x = (mDir == right) ? mPos.x + `GAME_STEP : mPos.x - `GAME_STEP;
			if (m == rising) begin
				mPos.y = mPos.y - `GAME_STEP;        // up the screen
				mHeight = mHeight + `GAME_STEP;
			end else begin
				if (m == falling) mPos.y = mPos.y + `GAME_STEP;
				mHeight = '0;
			end
			stepCount++;
		end
		mMode = m;
		case (mState)
			init: mState = play;
			play: mState = fTick ? update : play;
			update: mState = goal ? endgame : play;
			default: mState = endgame;
		endcase
		// writes restart their own counter
		mFrameCnt = (fTick || (c.strobe && c.addr == cfgFramePeriod)) ? '0 : mFrameCnt + 28'd1;
		mTimerCnt = (tTick || (c.strobe && c.addr == cfgTimerPeriod)) ? '0 : mTimerCnt + 28'd1;
		if (c.strobe && c.addr == cfgFramePeriod) mFramePer = c.data;
		if (c.strobe && c.addr == cfgTimerPeriod) mTimerPer = c.data;
	endtask

	task automatic runCycle(input logic jumpIn, input cfgWrite c);
		compareAll();
		jump = jumpIn;                           // falling edge drive
		cfg = c;
		advanceModel(jumpIn, c);
		@(negedge clk);
	endtask

	task automatic applyReset();
		reset = 1'b1;
		jump = 1'b0;
		cfg = '0;
		repeat (16) @(negedge clk);
		mFramePer = `GAME_FRAME_PERIOD_DEF;
		mTimerPer = `GAME_TIMER_PERIOD_DEF;
		mFrameCnt = '0;
		mTimerCnt = '0;
		mState = init;
		mPos = '{x: `GAME_START_X, y: `GAME_START_Y};
		mDir = left;
		mMode = resting;
		mHeight = '0;
		foreach (mDig[i]) mDig[i] = '0;
		stepCount = 0;
		reset = 1'b0;
	endtask

	task automatic writeCfg(input cfgAddr a, input logic [27:0] d);
		runCycle(1'b0, '{strobe: 1'b1, addr: a, data: d});
	endtask

	task automatic runFrames(input int unsigned frames, input int unsigned pct);
		int unsigned target;
		int unsigned waited;
		int unsigned limit;
		int unsigned drawnAt;
		logic jumpLevel;
		target = stepCount + frames;
		limit = frames * (int'(mFramePer) + 4) + 50;
		waited = 0;
		drawnAt = stepCount;
		jumpLevel = 1'b0;
		while (stepCount < target && mState != endgame) begin
			if (stepCount != drawnAt) begin
				jumpLevel = ($unsigned($random(seed)) % 100) < pct;   // new draw each frame
				drawnAt = stepCount;
			end
			runCycle(jumpLevel, '0);
			waited++;
			if (waited > limit) timeoutFail("frame steps");
		end
	endtask

	// presses before steps 50, 74 and 102 climb ground, middle, top, then the goal
	task automatic climbToGoal();
		int unsigned waited;
		waited = 0;
		while (mState != endgame) begin
			runCycle(stepCount inside {49, 73, 101}, '0);
			waited++;
			if (waited > 2000) timeoutFail("the goal ledge");
		end
		checkValue("win", 64'(win), 64'd1);
	endtask

	task automatic checkFrozen();
		playerPos heldPos;
		hexDisplay heldDisp;
		heldPos = mPos;                          // model state when the goal was reached
		heldDisp = expectedDisplay();
		repeat (60) begin
			runCycle(1'b1, '0);                  // presses change nothing now
			checkValue("pos", 64'(pos), 64'(heldPos));
			checkValue("display", 64'(display), 64'(heldDisp));
		end
	endtask

	initial begin
		seed = 32'h2348_5399;
		reset = 1'b1;
		jump = 1'b0;
		cfg = '0;
		@(negedge clk);
		applyReset();
		checkValue("pos", 64'(pos), 64'({`GAME_START_X, `GAME_START_Y}));
		checkValue("win", 64'(win), 64'd0);
		checkValue("display", 64'(display), 64'({6{7'b100_0000}}));
		for (int r = 0; r < rowCount; r++) begin
			writeCfg(cfgFramePeriod, rows[r].framePer);
			writeCfg(cfgTimerPeriod, rows[r].timerPer);
			runFrames(rows[r].frames, rows[r].jumpPct);
		end
		applyReset();
		writeCfg(cfgFramePeriod, 28'd4);
		writeCfg(cfgTimerPeriod, 28'd2);
		climbToGoal();
		checkFrozen();
		$display("Finished with no errors");
		$finish;
	end

endmodule

// File: sim.f
+incdir+source
source/gamePkg.sv
source/timerPkg.sv
source/gameConfig.sv
source/tickGenerator.sv
source/gameControl.sv
source/platformMap.sv
source/playerMotion.sv
source/elapsedTimer.sv
source/gameTop.sv
tb/gameTop_sva.sv
tb/gameTopTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f sim.f --top-module gameTopTb -o gameTopSim

status=0
./obj_dir/gameTopSim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Finished with errors" sim.log || [ "$status" -ne 0 ]; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
